/* list.f */
source/core_pkg.sv
source/io_bus_pkg.sv
source/rr_arbiter.sv
source/io_request_queue.sv
source/io_interconnect.sv
source/io_register_device.sv
source/io_subsystem_top.sv
testbench/io_subsystem_asserts.sv
testbench/io_subsystem_tb.sv

/* Makefile */
# Verilator build for the uncached I/O path testbench

VERILATOR  ?= verilator
TOP        := io_subsystem_tb
FILE_LIST  := list.f
BUILD_DIR  := obj_dir
LOG        := sim.log
LINT_FLAGS := --lint-only --timing --assert --top-module $(TOP)
SIM_FLAGS  := --binary --timing --assert -j 0 --top-module $(TOP) --Mdir $(BUILD_DIR)
PASS_TEXT  := *** TEST PASSED ***

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILE_LIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILE_LIST)
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -qF '$(PASS_TEXT)' $(LOG) && echo "Simulation passed" || \
		(echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* testbench/io_subsystem_tb.sv */
//////////////////////////////
// Testbench for the two-core uncached I/O path
// Plays both data-cache stages, checks against a register model
//////////////////////////////

`default_nettype none

module io_subsystem_tb
	import core_pkg::*;
	import io_bus_pkg::*;
	();

	localparam int RESET_CYCLES = 16;
	localparam int WAKE_TIMEOUT = 60;
	localparam int RANDOM_OPS = 40;

	logic clk;
	logic reset;

	// Data-cache stage side, one slot per core
	logic [NUM_CORES - 1:0] io_write_en;
	logic [NUM_CORES - 1:0] io_read_en;
	thread_idx_t io_thread_idx[NUM_CORES];
	scalar_t io_addr[NUM_CORES];
	scalar_t io_write_value[NUM_CORES];
	scalar_t read_value[NUM_CORES];
	logic [NUM_CORES - 1:0] rollback_en;
	logic [THREADS_PER_CORE - 1:0] wake_bitmap[NUM_CORES];

	// Expected device register contents
	scalar_t ref_regs[NUM_IO_REGS];
	integer seed;

	io_subsystem_top #(.RESPONSE_LATENCY(3)) uut(
		.clk(clk),
		.reset(reset),
		.io_write_en_0(io_write_en[0]),
		.io_read_en_0(io_read_en[0]),
		.io_thread_idx_0(io_thread_idx[0]),
		.io_addr_0(io_addr[0]),
		.io_write_value_0(io_write_value[0]),
		.read_value_0(read_value[0]),
		.rollback_en_0(rollback_en[0]),
		.wake_bitmap_0(wake_bitmap[0]),
		.io_write_en_1(io_write_en[1]),
		.io_read_en_1(io_read_en[1]),
		.io_thread_idx_1(io_thread_idx[1]),
		.io_addr_1(io_addr[1]),
		.io_write_value_1(io_write_value[1]),
		.read_value_1(read_value[1]),
		.rollback_en_1(rollback_en[1]),
		.wake_bitmap_1(wake_bitmap[1]));

	always #5 clk = ~clk;

	// Device decodes the word index from address bits 5:2
	function automatic int reg_index(input scalar_t addr);
		return int'(addr[5:2]);
	endfunction

	task automatic stop_with_failure(input string reason);
		$display("%s", reason);
		$display("*** TEST FAILED ***");
		$fatal(1, "Simulation stopped at the first failed check");
	endtask

	task automatic check_value(input string name, input scalar_t got, input scalar_t expected);
		assert (got === expected)
		else
			stop_with_failure($sformatf("ERROR at time %0t: %s is %h, expected %h",
				$time, name, got, expected));
	endtask

	// Present one operation to a core, held until cleared
	task automatic drive_strobe(input int core, input int thread, input bit is_store,
		input scalar_t addr, input scalar_t value);
		io_write_en[core] = is_store;
		io_read_en[core] = !is_store;
		io_thread_idx[core] = thread_idx_t'(thread);
		io_addr[core] = addr;
		io_write_value[core] = value;
	endtask

	task automatic clear_strobe(input int core);
		io_write_en[core] = 1'b0;
		io_read_en[core] = 1'b0;
	endtask

	// Full issue, sleep, wake and re-issue sequence for one thread
	task automatic run_io_op(input int core, input int thread, input bit is_store,
		input scalar_t addr, input scalar_t value);
		scalar_t expected;
		int waited;
		int other;

		other = 1 - core;
		// Store echoes the written word, load returns register contents
		if (is_store)
		begin
			ref_regs[reg_index(addr)] = value;
			expected = value;
		end
		else
			expected = ref_regs[reg_index(addr)];

		drive_strobe(core, thread, is_store, addr, value);
		@(negedge clk);
		clear_strobe(core);
		check_value($sformatf("rollback_en_%0d", core), 32'(rollback_en[core]), 32'd1);

		// Thread sleeps until its response shows up
		waited = 0;
		while (!wake_bitmap[core][thread])
		begin
			if (waited >= WAKE_TIMEOUT)
				stop_with_failure($sformatf("Core %0d thread %0d was never woken",
					core, thread));
			@(negedge clk);
			waited++;
		end
		check_value($sformatf("wake_bitmap_%0d", core), 32'(wake_bitmap[core]),
			32'(1) << thread);
		check_value($sformatf("wake_bitmap_%0d", other), 32'(wake_bitmap[other]), 32'd0);

		// Woken thread re-issues on a later cycle
		@(negedge clk);
		drive_strobe(core, thread, is_store, addr, value);
		@(negedge clk);
		clear_strobe(core);
		check_value($sformatf("rollback_en_%0d", core), 32'(rollback_en[core]), 32'd0);
		check_value($sformatf("read_value_%0d", core), read_value[core], expected);
	endtask

	task automatic test_reset_state();
		for (int c = 0; c < NUM_CORES; c++)
		begin
			check_value($sformatf("rollback_en_%0d", c), 32'(rollback_en[c]), 32'd0);
			check_value($sformatf("wake_bitmap_%0d", c), 32'(wake_bitmap[c]), 32'd0);
			check_value($sformatf("read_value_%0d", c), read_value[c], 32'd0);
		end
	endtask

	task automatic test_store_then_load();
		run_io_op(0, 1, 1'b1, 32'h8000_0014, 32'hcafe_f00d);
		run_io_op(0, 1, 1'b0, 32'h8000_0014, 32'd0);
		// Other core and thread on a different register
		run_io_op(1, 3, 1'b1, 32'h8000_0020, 32'h1234_5678);
		run_io_op(1, 3, 1'b0, 32'h8000_0020, 32'd0);
	endtask

	// Eight stores in flight at once, device takes them one by one
	task automatic test_all_thread_burst();
		scalar_t values[NUM_CORES][THREADS_PER_CORE];
		logic [NUM_CORES * THREADS_PER_CORE - 1:0] woken;
		int waited;

		woken = '0;
		for (int t = 0; t < THREADS_PER_CORE; t++)
		begin
			for (int c = 0; c < NUM_CORES; c++)
			begin
				values[c][t] = $random(seed);
				ref_regs[c * THREADS_PER_CORE + t] = values[c][t];
				drive_strobe(c, t, 1'b1, scalar_t'((c * THREADS_PER_CORE + t) << 2),
					values[c][t]);
			end
			@(negedge clk);
			woken = woken | {wake_bitmap[1], wake_bitmap[0]};
			for (int c = 0; c < NUM_CORES; c++)
				check_value($sformatf("rollback_en_%0d", c), 32'(rollback_en[c]), 32'd1);
		end
		clear_strobe(0);
		clear_strobe(1);

		// Collect every wake pulse
		waited = 0;
		while (woken != '1)
		begin
			if (waited >= WAKE_TIMEOUT * 4)
				stop_with_failure($sformatf("Burst stores not all woken, seen %b", woken));
			@(negedge clk);
			woken = woken | {wake_bitmap[1], wake_bitmap[0]};
			waited++;
		end
		@(negedge clk);

		// Complete all eight, one thread per core each cycle
		for (int t = 0; t < THREADS_PER_CORE; t++)
		begin
			for (int c = 0; c < NUM_CORES; c++)
				drive_strobe(c, t, 1'b1, scalar_t'((c * THREADS_PER_CORE + t) << 2),
					values[c][t]);
			@(negedge clk);
			for (int c = 0; c < NUM_CORES; c++)
			begin
				check_value($sformatf("rollback_en_%0d", c), 32'(rollback_en[c]), 32'd0);
				check_value($sformatf("read_value_%0d", c), read_value[c], values[c][t]);
			end
		end
		clear_strobe(0);
		clear_strobe(1);

		// Read every register back through a different thread
		for (int r = 0; r < NUM_CORES * THREADS_PER_CORE; r++)
			run_io_op(r % NUM_CORES, (r + 1) % THREADS_PER_CORE, 1'b0,
				scalar_t'(r << 2), 32'd0);
	endtask

	task automatic test_random_sequence();
		int core;
		int thread;
		bit is_store;
		scalar_t addr;
		scalar_t value;

		for (int n = 0; n < RANDOM_OPS; n++)
		begin
			core = int'($random(seed) & 1);
			thread = int'($random(seed) & (THREADS_PER_CORE - 1));
			is_store = ($random(seed) & 1) != 0;
			// Upper address bits are random and ignored by the device
			addr = $random(seed);
			addr[1:0] = 2'b00;
			value = $random(seed);
			run_io_op(core, thread, is_store, addr, value);
		end
	endtask

	initial
	begin
		seed = 24;
		clk = 1'b0;
		reset = 1'b1;
		io_write_en = '0;
		io_read_en = '0;
		for (int c = 0; c < NUM_CORES; c++)
		begin
			io_thread_idx[c] = '0;
			io_addr[c] = '0;
			io_write_value[c] = '0;
		end
		for (int i = 0; i < NUM_IO_REGS; i++)
			ref_regs[i] = '0;

		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		test_reset_state();
		test_store_then_load();
		test_all_thread_burst();
		test_random_sequence();

		// Bound queue checks must also be clean
		if (uut.io_request_queue_0.queue_asserts.fail_count == 0
			&& uut.io_request_queue_1.queue_asserts.fail_count == 0)
		begin
			$display("*** TEST PASSED ***");
			$finish;
		end
		else
			stop_with_failure("A bound assertion on a request queue failed");
	end

endmodule

`default_nettype wire

/* testbench/io_subsystem_asserts.sv */
//////////////////////////////
// Concurrent checks on the request queue handshakes
// Bound into every io_request_queue instance
//////////////////////////////

`default_nettype none

module io_subsystem_asserts
	import core_pkg::*;
	(
		input logic                          clk,
		input logic                          reset,
		input logic [THREADS_PER_CORE - 1:0] entry_valid,
		input logic [THREADS_PER_CORE - 1:0] entry_sent,
		input logic                          response_hit,
		input thread_idx_t                   response_thread_idx,
		input logic                          request_valid,
		input logic                          ready
	);

	// Failed checks in this queue instance
	int unsigned fail_count = 0;

	// Response must match an entry that is pending and already sent
	response_for_pending: assert property (@(posedge clk) disable iff (reset)
		response_hit |-> entry_valid[response_thread_idx] && entry_sent[response_thread_idx])
	else
	begin
		fail_count++;
		$error("Response for thread %0d with no pending entry", response_thread_idx);
	end

	// Interconnect only accepts a presented request
	ready_needs_request: assert property (@(posedge clk) disable iff (reset)
		ready |-> request_valid)
	else
	begin
		fail_count++;
		$error("Ready given to a queue with no request");
	end

	// Request held until it is taken
	request_held: assert property (@(posedge clk) disable iff (reset)
		request_valid && !ready |=> request_valid)
	else
	begin
		fail_count++;
		$error("Request dropped before acceptance");
	end

endmodule

bind io_request_queue io_subsystem_asserts queue_asserts(
	.clk(clk),
	.reset(reset),
	.entry_valid(entry_valid),
	.entry_sent(entry_sent),
	.response_hit(response_hit),
	.response_thread_idx(response_thread_idx),
	.request_valid(request_valid),
	.ready(ready));

`default_nettype wire

/* source/io_subsystem_top.sv */
//////////////////////////////
// Two-core uncached I/O path: queues, interconnect, register device
// Core ports carry suffix _0 and _1
//////////////////////////////

`default_nettype none

module io_subsystem_top
	import core_pkg::*;
	import io_bus_pkg::*;
	#(parameter int RESPONSE_LATENCY = 3)
	(
		input logic                           clk,
		input logic                           reset,

		// Core 0
		input logic                           io_write_en_0,
		input logic                           io_read_en_0,
		input thread_idx_t                    io_thread_idx_0,
		input scalar_t                        io_addr_0,
		input scalar_t                        io_write_value_0,
		output scalar_t                       read_value_0,
		output logic                          rollback_en_0,
		output logic [THREADS_PER_CORE - 1:0] wake_bitmap_0,

		// Core 1
		input logic                           io_write_en_1,
		input logic                           io_read_en_1,
		input thread_idx_t                    io_thread_idx_1,
		input scalar_t                        io_addr_1,
		input scalar_t                        io_write_value_1,
		output scalar_t                       read_value_1,
		output logic                          rollback_en_1,
		output logic [THREADS_PER_CORE - 1:0] wake_bitmap_1
	);

	// Queue to interconnect, indexed by core
	logic [NUM_CORES - 1:0] request_valid;
	logic [NUM_CORES - 1:0] request_is_store;
	scalar_t request_address[NUM_CORES];
	scalar_t request_value[NUM_CORES];
	thread_idx_t request_thread_idx[NUM_CORES];
	logic [NUM_CORES - 1:0] ready;

	// Interconnect to device
	logic dev_request_valid;
	logic dev_is_store;
	scalar_t dev_address;
	scalar_t dev_value;
	core_idx_t dev_core;
	thread_idx_t dev_thread_idx;
	logic dev_ready;

	// Response seen by both queues
	logic response_valid;
	core_idx_t response_core;
	thread_idx_t response_thread_idx;
	scalar_t response_read_value;

	io_request_queue #(.CORE_ID(0)) io_request_queue_0(
		.clk(clk),
		.reset(reset),
		.io_write_en(io_write_en_0),
		.io_read_en(io_read_en_0),
		.io_thread_idx(io_thread_idx_0),
		.io_addr(io_addr_0),
		.io_write_value(io_write_value_0),
		.read_value(read_value_0),
		.rollback_en(rollback_en_0),
		.wake_bitmap(wake_bitmap_0),
		.request_valid(request_valid[0]),
		.request_is_store(request_is_store[0]),
		.request_address(request_address[0]),
		.request_value(request_value[0]),
		.request_thread_idx(request_thread_idx[0]),
		.ready(ready[0]),
		.response_valid(response_valid),
		.response_core(response_core),
		.response_thread_idx(response_thread_idx),
		.response_read_value(response_read_value));

	io_request_queue #(.CORE_ID(1)) io_request_queue_1(
		.clk(clk),
		.reset(reset),
		.io_write_en(io_write_en_1),
		.io_read_en(io_read_en_1),
		.io_thread_idx(io_thread_idx_1),
		.io_addr(io_addr_1),
		.io_write_value(io_write_value_1),
		.read_value(read_value_1),
		.rollback_en(rollback_en_1),
		.wake_bitmap(wake_bitmap_1),
		.request_valid(request_valid[1]),
		.request_is_store(request_is_store[1]),
		.request_address(request_address[1]),
		.request_value(request_value[1]),
		.request_thread_idx(request_thread_idx[1]),
		.ready(ready[1]),
		.response_valid(response_valid),
		.response_core(response_core),
		.response_thread_idx(response_thread_idx),
		.response_read_value(response_read_value));

	io_interconnect io_interconnect(
		.clk(clk),
		.reset(reset),
		.request_valid(request_valid),
		.request_is_store(request_is_store),
		.request_address(request_address),
		.request_value(request_value),
		.request_thread_idx(request_thread_idx),
		.ready(ready),
		.dev_request_valid(dev_request_valid),
		.dev_is_store(dev_is_store),
		.dev_address(dev_address),
		.dev_value(dev_value),
		.dev_core(dev_core),
		.dev_thread_idx(dev_thread_idx),
		.dev_ready(dev_ready));

	io_register_device #(.RESPONSE_LATENCY(RESPONSE_LATENCY)) io_register_device(
		.clk(clk),
		.reset(reset),
		.dev_request_valid(dev_request_valid),
		.dev_is_store(dev_is_store),
		.dev_address(dev_address),
		.dev_value(dev_value),
		.dev_core(dev_core),
		.dev_thread_idx(dev_thread_idx),
		.dev_ready(dev_ready),
		.response_valid(response_valid),
		.response_core(response_core),
		.response_thread_idx(response_thread_idx),
		.response_read_value(response_read_value));

endmodule

`default_nettype wire

/* source/io_register_device.sv */
//////////////////////////////
// Memory-mapped register bank with fixed response latency
// One request in flight, response broadcast to all cores
//////////////////////////////

`default_nettype none

module io_register_device
	import core_pkg::*;
	import io_bus_pkg::*;
	#(parameter int RESPONSE_LATENCY = 3)
	(
		input logic          clk,
		input logic          reset,

		// Request from the interconnect
		input logic          dev_request_valid,
		input logic          dev_is_store,
		input scalar_t       dev_address,
		input scalar_t       dev_value,
		input core_idx_t     dev_core,
		input thread_idx_t   dev_thread_idx,
		output logic         dev_ready,

		// Broadcast response
		output logic         response_valid,
		output core_idx_t    response_core,
		output thread_idx_t  response_thread_idx,
		output scalar_t      response_read_value
	);

	localparam int COUNT_WIDTH = $clog2(RESPONSE_LATENCY + 1);

	scalar_t io_regs[NUM_IO_REGS];
	logic [COUNT_WIDTH - 1:0] countdown;
	io_reg_idx_t reg_idx;
	logic accept;

	// Tags and data held until the response cycle
	core_idx_t held_core;
	thread_idx_t held_thread_idx;
	scalar_t held_value;

	assign reg_idx = dev_address[IO_REG_IDX_MSB:IO_REG_IDX_LSB];
	assign accept = dev_request_valid && dev_ready;

	// Idle when nothing is counting down
	assign dev_ready = countdown == '0;
	// Last count is the response cycle
	assign response_valid = countdown == COUNT_WIDTH'(1);

	// Register bank and countdown
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			countdown <= '0;
			for (int i = 0; i < NUM_IO_REGS; i++)
				io_regs[i] <= '0;
		end
		else if (accept)
		begin
			countdown <= COUNT_WIDTH'(RESPONSE_LATENCY);
			// Store takes effect at acceptance
			if (dev_is_store)
				io_regs[reg_idx] <= dev_value;
		end
		else if (countdown != '0)
			countdown <= countdown - 1'b1;
	end

	// Capture response payload at acceptance
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			held_core <= dev_core;
			held_thread_idx <= dev_thread_idx;
			// Store echoes written data, load returns register contents
			held_value <= dev_is_store ? dev_value : io_regs[reg_idx];
		end
	end

	assign response_core = held_core;
	assign response_thread_idx = held_thread_idx;
	assign response_read_value = held_value;

endmodule

`default_nettype wire

/* source/io_interconnect.sv */
//////////////////////////////
// Selects one core's I/O request per cycle for the device
// Tags it with the core index so the response can be claimed
//////////////////////////////

`default_nettype none

module io_interconnect
	import core_pkg::*;
	import io_bus_pkg::*;
	(
		input logic                    clk,
		input logic                    reset,

		// Requests from the per-core queues
		input logic [NUM_CORES - 1:0]  request_valid,
		input logic [NUM_CORES - 1:0]  request_is_store,
		input scalar_t                 request_address[NUM_CORES],
		input scalar_t                 request_value[NUM_CORES],
		input thread_idx_t             request_thread_idx[NUM_CORES],

		// Acceptance back to each queue
		output logic [NUM_CORES - 1:0] ready,

		// Toward the register device
		output logic                   dev_request_valid,
		output logic                   dev_is_store,
		output scalar_t                dev_address,
		output scalar_t                dev_value,
		output core_idx_t              dev_core,
		output thread_idx_t            dev_thread_idx,
		input logic                    dev_ready
	);

	logic [NUM_CORES - 1:0] core_grant_oh;
	core_idx_t core_grant_idx;
	logic accept;

	// Rotate between cores, advance only on a real transfer
	rr_arbiter #(.NUM_ENTRIES(NUM_CORES)) core_arbiter(
		.clk(clk),
		.reset(reset),
		.request(request_valid),
		.update(accept),
		.grant_oh(core_grant_oh),
		.grant_idx(core_grant_idx));

	// Transfer when a core wins and the device is idle
	assign accept = |core_grant_oh && dev_ready;

	// Only the winner sees ready
	assign ready = dev_ready ? core_grant_oh : '0;

	// Winner's fields onto the device port
	assign dev_request_valid = accept;
	assign dev_is_store = request_is_store[core_grant_idx];
	assign dev_address = request_address[core_grant_idx];
	assign dev_value = request_value[core_grant_idx];
	assign dev_thread_idx = request_thread_idx[core_grant_idx];

	// Source core rides along for response routing
	assign dev_core = core_grant_idx;

endmodule

`default_nettype wire

/* source/io_request_queue.sv */
//////////////////////////////
// Per-core table of pending uncached loads and stores
// First strobe rolls the thread back, response wakes it, second strobe completes
//////////////////////////////

`default_nettype none

module io_request_queue
	import core_pkg::*;
	import io_bus_pkg::*;
	#(parameter int CORE_ID = 0)
	(
		input logic                           clk,
		input logic                           reset,

		// Data-cache stage strobes
		input logic                           io_write_en,
		input logic                           io_read_en,
		input thread_idx_t                    io_thread_idx,
		input scalar_t                        io_addr,
		input scalar_t                        io_write_value,

		// Back to the core
		output scalar_t                       read_value,
		output logic                          rollback_en,
		output logic [THREADS_PER_CORE - 1:0] wake_bitmap,

		// Request toward the interconnect
		output logic                          request_valid,
		output logic                          request_is_store,
		output scalar_t                       request_address,
		output scalar_t                       request_value,
		output thread_idx_t                   request_thread_idx,

		// From the interconnect
		input logic                           ready,
		input logic                           response_valid,
		input core_idx_t                      response_core,
		input thread_idx_t                    response_thread_idx,
		input scalar_t                        response_read_value
	);

	// Control state per thread
	logic [THREADS_PER_CORE - 1:0] entry_valid;
	logic [THREADS_PER_CORE - 1:0] entry_sent;

	// Payload per thread
	logic [THREADS_PER_CORE - 1:0] entry_is_store;
	scalar_t entry_address[THREADS_PER_CORE];
	scalar_t entry_value[THREADS_PER_CORE];

	logic [THREADS_PER_CORE - 1:0] send_request;
	logic [THREADS_PER_CORE - 1:0] send_grant_oh;
	thread_idx_t send_grant_idx;
	logic [THREADS_PER_CORE - 1:0] wake_thread_oh;
	logic io_strobe;
	logic response_hit;
	logic request_accept;

	assign io_strobe = io_write_en | io_read_en;
	// Response is for this core
	assign response_hit = response_valid && response_core == core_idx_t'(CORE_ID);
	assign request_accept = request_valid && ready;

	// Waiting entries compete for the request port
	assign send_request = entry_valid & ~entry_sent;

	rr_arbiter #(.NUM_ENTRIES(THREADS_PER_CORE)) send_arbiter(
		.clk(clk),
		.reset(reset),
		.request(send_request),
		.update(request_accept),
		.grant_oh(send_grant_oh),
		.grant_idx(send_grant_idx));

	// Valid and sent flags
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			entry_valid <= '0;
			entry_sent <= '0;
		end
		else
		begin
			for (int i = 0; i < THREADS_PER_CORE; i++)
			begin
				if (io_strobe && io_thread_idx == thread_idx_t'(i))
				begin
					if (entry_valid[i])
					begin
						// Re-issue after wake, transaction done
						entry_valid[i] <= 1'b0;
					end
					else
					begin
						// New transaction
						entry_valid[i] <= 1'b1;
						entry_sent[i] <= 1'b0;
					end
				end

				// Taken by the interconnect, never sent again
				if (request_accept && send_grant_idx == thread_idx_t'(i))
					entry_sent[i] <= 1'b1;
			end
		end
	end

	// Operation and data, response overwrites the value
	always_ff @(posedge clk)
	begin
		for (int i = 0; i < THREADS_PER_CORE; i++)
		begin
			if (io_strobe && io_thread_idx == thread_idx_t'(i) && !entry_valid[i])
			begin
				entry_is_store[i] <= io_write_en;
				entry_address[i] <= io_addr;
				entry_value[i] <= io_write_value;
			end
			else if (response_hit && response_thread_idx == thread_idx_t'(i))
				entry_value[i] <= response_read_value;
		end
	end

	// Arbiter winner drives the request port
	assign request_valid = |send_grant_oh;
	assign request_is_store = entry_is_store[send_grant_idx];
	assign request_address = entry_address[send_grant_idx];
	assign request_value = entry_value[send_grant_idx];
	assign request_thread_idx = send_grant_idx;

	// Decode responding thread for wake
	always_comb
	begin
		wake_thread_oh = '0;
		wake_thread_oh[response_thread_idx] = 1'b1;
	end

	// Same cycle as the response
	assign wake_bitmap = response_hit ? wake_thread_oh : '0;

	// Rollback on start, returned value on completion
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			rollback_en <= 1'b0;
			read_value <= '0;
		end
		else
		begin
			rollback_en <= io_strobe && !entry_valid[io_thread_idx];
			if (io_strobe && entry_valid[io_thread_idx])
				read_value <= entry_value[io_thread_idx];
		end
	end

endmodule

`default_nettype wire

/* source/rr_arbiter.sv */
//////////////////////////////
// Round-robin arbiter with one-hot and binary grant
// Priority moves past the winner only when update is asserted
//////////////////////////////

`default_nettype none

module rr_arbiter
	#(parameter int NUM_ENTRIES = 4)
	(
		input logic                               clk,
		input logic                               reset,

		// One bit per requester
		input logic [NUM_ENTRIES - 1:0]           request,

		// Grant was taken this cycle
		input logic                               update,

		output logic [NUM_ENTRIES - 1:0]          grant_oh,
		output logic [$clog2(NUM_ENTRIES) - 1:0]  grant_idx
	);

	// Index of the most recent winner, search starts just after it
	logic [$clog2(NUM_ENTRIES) - 1:0] last_winner;

	// Scan in rotating order, first requester found wins
	always_comb
	begin
		logic found;
		int unsigned candidate;

		found = 1'b0;
		grant_oh = '0;
		grant_idx = '0;
		for (int offset = 1; offset <= NUM_ENTRIES; offset++)
		begin
			candidate = (int'(last_winner) + offset) % NUM_ENTRIES;
			if (!found && request[candidate])
			begin
				found = 1'b1;
				grant_oh[candidate] = 1'b1;
				grant_idx = candidate[$clog2(NUM_ENTRIES) - 1:0];
			end
		end
	end

	// Pointer only advances on an accepted grant
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			// Entry 0 has priority first after reset
			last_winner <= $clog2(NUM_ENTRIES)'(NUM_ENTRIES - 1);
		end
		else if (update && |request)
			last_winner <= grant_idx;
	end

endmodule

`default_nettype wire

/* source/io_bus_pkg.sv */
//////////////////////////////
// I/O bus types between the cores and the register device
// Holds core numbering and the device address map
//////////////////////////////

`default_nettype none

package io_bus_pkg;

	// Cores sharing the I/O bus
	localparam int NUM_CORES = 2;
	typedef logic [$clog2(NUM_CORES) - 1:0] core_idx_t;

	// Register bank of the device, one word per register
	localparam int NUM_IO_REGS = 16;
	typedef logic [$clog2(NUM_IO_REGS) - 1:0] io_reg_idx_t;

	// Word-aligned register select taken from the address
	localparam int IO_REG_IDX_LSB = 2;
	localparam int IO_REG_IDX_MSB = IO_REG_IDX_LSB + $clog2(NUM_IO_REGS) - 1;

endpackage

`default_nettype wire

/* source/core_pkg.sv */
//////////////////////////////
// Core-side widths and types shared by the I/O request path
// Imported by any module that carries thread indices or data words
//////////////////////////////

`default_nettype none

package core_pkg;

	// Hardware threads in each core
	localparam int THREADS_PER_CORE = 4;

	// Thread number within one core
	typedef logic [$clog2(THREADS_PER_CORE) - 1:0] thread_idx_t;

	// One data or address word
	typedef logic [31:0] scalar_t;

endpackage

`default_nettype wire
